/* Bender.yml */
package:
  name: branch_predictor

sources:
  - source/bp_pkg.sv
  - source/resolve_stage.sv
  - source/branch_target_buffer.sv
  - source/local_predictor.sv
  - source/gshare_predictor.sv
  - source/predictor_chooser.sv
  - source/branch_predictor.sv
  - target: test
    files:
      - tests/branch_predictor_chk.sv
      - tests/branch_predictor_tb.sv

/* source/bp_pkg.sv */
package bp_pkg;

    // byte address as seen by fetch
    typedef logic [31:0] addr_t;

    // one-bit pattern state
    typedef enum logic {
        not_taken = 1'b0,
        taken     = 1'b1
    } pht_state_t;

    // default sizes for the top level parameters
    parameter int DEFAULT_FETCH_WIDTH    = 2;
    parameter int DEFAULT_BTB_INDEX_BITS = 4;
    parameter int DEFAULT_BHT_INDEX_BITS = 4;
    parameter int DEFAULT_HISTORY_BITS   = 4;

endpackage

/* source/branch_predictor.sv */
`timescale 1ns/1ps

module branch_predictor import bp_pkg::*; #(
    parameter int FETCH_WIDTH    = DEFAULT_FETCH_WIDTH,
    parameter int BTB_INDEX_BITS = DEFAULT_BTB_INDEX_BITS,
    parameter int BHT_INDEX_BITS = DEFAULT_BHT_INDEX_BITS,
    parameter int HISTORY_BITS   = DEFAULT_HISTORY_BITS
) (
    input  logic                      clock,
    input  logic                      reset,
    input  addr_t                     pc_start,
    input  logic  [FETCH_WIDTH-1:0]   resolve_valid,
    input  addr_t [FETCH_WIDTH-1:0]   resolve_pc,
    input  logic  [FETCH_WIDTH-1:0]   resolve_taken,
    input  addr_t [FETCH_WIDTH-1:0]   resolve_target,
    output logic  [FETCH_WIDTH-1:0]   predict_taken,
    output addr_t [FETCH_WIDTH-1:0]   predict_pc
);

    logic  [FETCH_WIDTH-1:0] upd_valid;
    addr_t [FETCH_WIDTH-1:0] upd_pc;
    logic  [FETCH_WIDTH-1:0] upd_taken;
    addr_t [FETCH_WIDTH-1:0] upd_target;

    logic  [FETCH_WIDTH-1:0] local_taken;
    addr_t [FETCH_WIDTH-1:0] local_pc;
    logic  [FETCH_WIDTH-1:0] local_correct;
    logic  [FETCH_WIDTH-1:0] gshare_taken;
    addr_t [FETCH_WIDTH-1:0] gshare_pc;
    logic  [FETCH_WIDTH-1:0] gshare_correct;

    resolve_stage #(
        .FETCH_WIDTH (FETCH_WIDTH)
    ) resolve_i (
        .clock          (clock),
        .reset          (reset),
        .resolve_valid  (resolve_valid),
        .resolve_pc     (resolve_pc),
        .resolve_taken  (resolve_taken),
        .resolve_target (resolve_target),
        .upd_valid      (upd_valid),
        .upd_pc         (upd_pc),
        .upd_taken      (upd_taken),
        .upd_target     (upd_target)
    );

    local_predictor #(
        .FETCH_WIDTH    (FETCH_WIDTH),
        .BTB_INDEX_BITS (BTB_INDEX_BITS),
        .BHT_INDEX_BITS (BHT_INDEX_BITS),
        .HISTORY_BITS   (HISTORY_BITS)
    ) local_i (
        .clock      (clock),
        .reset      (reset),
        .pc_start   (pc_start),
        .upd_valid  (upd_valid),
        .upd_pc     (upd_pc),
        .upd_taken  (upd_taken),
        .upd_target (upd_target),
        .slot_taken (local_taken),
        .slot_pc    (local_pc),
        .correct    (local_correct)
    );

    gshare_predictor #(
        .FETCH_WIDTH    (FETCH_WIDTH),
        .BTB_INDEX_BITS (BTB_INDEX_BITS),
        .HISTORY_BITS   (HISTORY_BITS)
    ) gshare_i (
        .clock      (clock),
        .reset      (reset),
        .pc_start   (pc_start),
        .upd_valid  (upd_valid),
        .upd_pc     (upd_pc),
        .upd_taken  (upd_taken),
        .upd_target (upd_target),
        .slot_taken (gshare_taken),
        .slot_pc    (gshare_pc),
        .correct    (gshare_correct)
    );

    predictor_chooser #(
        .FETCH_WIDTH (FETCH_WIDTH)
    ) chooser_i (
        .clock          (clock),
        .reset          (reset),
        .upd_valid      (upd_valid),
        .local_taken    (local_taken),
        .local_pc       (local_pc),
        .local_correct  (local_correct),
        .gshare_taken   (gshare_taken),
        .gshare_pc      (gshare_pc),
        .gshare_correct (gshare_correct),
        .predict_taken  (predict_taken),
        .predict_pc     (predict_pc)
    );

endmodule

/* source/branch_target_buffer.sv */
`timescale 1ns/1ps

module branch_target_buffer import bp_pkg::*; #(
    parameter int FETCH_WIDTH    = DEFAULT_FETCH_WIDTH,
    parameter int BTB_INDEX_BITS = DEFAULT_BTB_INDEX_BITS
) (
    input  logic                      clock,
    input  logic                      reset,
    input  addr_t [FETCH_WIDTH-1:0]   lookup_pc,
    input  logic  [FETCH_WIDTH-1:0]   upd_valid,
    input  addr_t [FETCH_WIDTH-1:0]   upd_pc,
    input  logic  [FETCH_WIDTH-1:0]   upd_taken,
    input  addr_t [FETCH_WIDTH-1:0]   upd_target,
    output logic  [FETCH_WIDTH-1:0]   hit,
    output addr_t [FETCH_WIDTH-1:0]   target
);

    localparam int BTB_SIZE = 2 ** BTB_INDEX_BITS;
    localparam int TAG_BITS = 32 - BTB_INDEX_BITS - 2;

    logic                entry_valid  [BTB_SIZE];
    logic [TAG_BITS-1:0] entry_tag    [BTB_SIZE];
    addr_t               entry_target [BTB_SIZE];

    genvar gi;
    generate
        for (gi = 0; gi < FETCH_WIDTH; gi++) begin : g_lookup
            logic [BTB_INDEX_BITS-1:0] idx;
            logic [TAG_BITS-1:0]       tag;

            assign idx         = lookup_pc[gi][BTB_INDEX_BITS+1:2];
            assign tag         = lookup_pc[gi][31:BTB_INDEX_BITS+2];
            assign hit[gi]     = entry_valid[idx] && (entry_tag[idx] == tag);
            assign target[gi]  = entry_target[idx];
        end
    endgenerate

    // later slots are written last, so they win on a shared index
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int e = 0; e < BTB_SIZE; e++) begin
                entry_valid[e]  <= 1'b0;
                entry_tag[e]    <= '0;
                entry_target[e] <= '0;
            end
        end else begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                if (upd_valid[i] && upd_taken[i]) begin
                    entry_valid[upd_pc[i][BTB_INDEX_BITS+1:2]]  <= 1'b1;
                    entry_tag[upd_pc[i][BTB_INDEX_BITS+1:2]]    <= upd_pc[i][31:BTB_INDEX_BITS+2];
                    entry_target[upd_pc[i][BTB_INDEX_BITS+1:2]] <= upd_target[i];
                end
            end
        end
    end

endmodule

/* source/gshare_predictor.sv */
`timescale 1ns/1ps

module gshare_predictor import bp_pkg::*; #(
    parameter int FETCH_WIDTH    = DEFAULT_FETCH_WIDTH,
    parameter int BTB_INDEX_BITS = DEFAULT_BTB_INDEX_BITS,
    parameter int HISTORY_BITS   = DEFAULT_HISTORY_BITS
) (
    input  logic                      clock,
    input  logic                      reset,
    input  addr_t                     pc_start,
    input  logic  [FETCH_WIDTH-1:0]   upd_valid,
    input  addr_t [FETCH_WIDTH-1:0]   upd_pc,
    input  logic  [FETCH_WIDTH-1:0]   upd_taken,
    input  addr_t [FETCH_WIDTH-1:0]   upd_target,
    output logic  [FETCH_WIDTH-1:0]   slot_taken,
    output addr_t [FETCH_WIDTH-1:0]   slot_pc,
    output logic  [FETCH_WIDTH-1:0]   correct
);

    localparam int PHT_SIZE = 2 ** HISTORY_BITS;

    logic [HISTORY_BITS-1:0] ghr;
    logic [HISTORY_BITS-1:0] ghr_next;
    pht_state_t              pht      [PHT_SIZE];
    pht_state_t              pht_next [PHT_SIZE];

    addr_t [FETCH_WIDTH-1:0] lookup_pc;
    logic  [FETCH_WIDTH-1:0] btb_hit;
    addr_t [FETCH_WIDTH-1:0] btb_target;

    branch_target_buffer #(
        .FETCH_WIDTH    (FETCH_WIDTH),
        .BTB_INDEX_BITS (BTB_INDEX_BITS)
    ) btb_i (
        .clock      (clock),
        .reset      (reset),
        .lookup_pc  (lookup_pc),
        .upd_valid  (upd_valid),
        .upd_pc     (upd_pc),
        .upd_taken  (upd_taken),
        .upd_target (upd_target),
        .hit        (btb_hit),
        .target     (btb_target)
    );

    genvar gi;
    generate
        for (gi = 0; gi < FETCH_WIDTH; gi++) begin : g_slot
            logic [HISTORY_BITS-1:0] idx;

            if (gi == 0) begin : g_first
                assign lookup_pc[gi] = pc_start;
            end else begin : g_chain
                assign lookup_pc[gi] = slot_pc[gi-1];
            end

            assign idx            = ghr ^ lookup_pc[gi][HISTORY_BITS+1:2];
            assign slot_taken[gi] = (pht[idx] == taken) && btb_hit[gi];
            assign slot_pc[gi]    = slot_taken[gi] ? btb_target[gi] : lookup_pc[gi] + 32'd4;
        end
    endgenerate

    // table index always from the history before this cycle's shifts
    always_comb begin
        logic [HISTORY_BITS-1:0] uidx;
        pht_state_t              dir;

        ghr_next = ghr;
        pht_next = pht;
        correct  = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            uidx = ghr ^ upd_pc[i][HISTORY_BITS+1:2];
            dir  = pht_state_t'(upd_taken[i]);
            if (upd_valid[i]) begin
                ghr_next       = {ghr_next[HISTORY_BITS-2:0], upd_taken[i]};
                pht_next[uidx] = dir;
                correct[i]     = (pht[uidx] == dir);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ghr <= '0;
            for (int e = 0; e < PHT_SIZE; e++) begin
                pht[e] <= not_taken;
            end
        end else begin
            ghr <= ghr_next;
            pht <= pht_next;
        end
    end

endmodule

/* source/local_predictor.sv */
`timescale 1ns/1ps

module local_predictor import bp_pkg::*; #(
    parameter int FETCH_WIDTH    = DEFAULT_FETCH_WIDTH,
    parameter int BTB_INDEX_BITS = DEFAULT_BTB_INDEX_BITS,
    parameter int BHT_INDEX_BITS = DEFAULT_BHT_INDEX_BITS,
    parameter int HISTORY_BITS   = DEFAULT_HISTORY_BITS
) (
    input  logic                      clock,
    input  logic                      reset,
    input  addr_t                     pc_start,
    input  logic  [FETCH_WIDTH-1:0]   upd_valid,
    input  addr_t [FETCH_WIDTH-1:0]   upd_pc,
    input  logic  [FETCH_WIDTH-1:0]   upd_taken,
    input  addr_t [FETCH_WIDTH-1:0]   upd_target,
    output logic  [FETCH_WIDTH-1:0]   slot_taken,
    output addr_t [FETCH_WIDTH-1:0]   slot_pc,
    output logic  [FETCH_WIDTH-1:0]   correct
);

    localparam int BHT_SIZE = 2 ** BHT_INDEX_BITS;
    localparam int PHT_SIZE = 2 ** HISTORY_BITS;

    logic [HISTORY_BITS-1:0] bht      [BHT_SIZE];
    logic [HISTORY_BITS-1:0] bht_next [BHT_SIZE];
    pht_state_t              pht      [PHT_SIZE];
    pht_state_t              pht_next [PHT_SIZE];

    addr_t [FETCH_WIDTH-1:0] lookup_pc;
    logic  [FETCH_WIDTH-1:0] btb_hit;
    addr_t [FETCH_WIDTH-1:0] btb_target;

    branch_target_buffer #(
        .FETCH_WIDTH    (FETCH_WIDTH),
        .BTB_INDEX_BITS (BTB_INDEX_BITS)
    ) btb_i (
        .clock      (clock),
        .reset      (reset),
        .lookup_pc  (lookup_pc),
        .upd_valid  (upd_valid),
        .upd_pc     (upd_pc),
        .upd_taken  (upd_taken),
        .upd_target (upd_target),
        .hit        (btb_hit),
        .target     (btb_target)
    );

    // each slot starts where the previous one is predicted to go
    genvar gi;
    generate
        for (gi = 0; gi < FETCH_WIDTH; gi++) begin : g_slot
            logic [BHT_INDEX_BITS-1:0] idx;

            if (gi == 0) begin : g_first
                assign lookup_pc[gi] = pc_start;
            end else begin : g_chain
                assign lookup_pc[gi] = slot_pc[gi-1];
            end

            assign idx            = lookup_pc[gi][BHT_INDEX_BITS+1:2];
            assign slot_taken[gi] = (pht[bht[idx]] == taken) && btb_hit[gi];
            assign slot_pc[gi]    = slot_taken[gi] ? btb_target[gi] : lookup_pc[gi] + 32'd4;
        end
    endgenerate

    always_comb begin
        logic [BHT_INDEX_BITS-1:0] uidx;
        logic [HISTORY_BITS-1:0]   old_hist;
        pht_state_t                dir;

        bht_next = bht;
        pht_next = pht;
        correct  = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            uidx     = upd_pc[i][BHT_INDEX_BITS+1:2];
            old_hist = bht[uidx];
            dir      = pht_state_t'(upd_taken[i]);
            if (upd_valid[i]) begin
                bht_next[uidx]     = {bht_next[uidx][HISTORY_BITS-2:0], upd_taken[i]};
                pht_next[old_hist] = dir;
                correct[i]         = (pht[old_hist] == dir);
            end
        end
    end

    // pattern table comes up with odd entries taken
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int e = 0; e < BHT_SIZE; e++) begin
                bht[e] <= '0;
            end
            for (int e = 0; e < PHT_SIZE; e++) begin
                pht[e] <= (e % 2 == 1) ? taken : not_taken;
            end
        end else begin
            bht <= bht_next;
            pht <= pht_next;
        end
    end

endmodule

/* source/predictor_chooser.sv */
`timescale 1ns/1ps

module predictor_chooser import bp_pkg::*; #(
    parameter int FETCH_WIDTH = DEFAULT_FETCH_WIDTH
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic  [FETCH_WIDTH-1:0]   upd_valid,
    input  logic  [FETCH_WIDTH-1:0]   local_taken,
    input  addr_t [FETCH_WIDTH-1:0]   local_pc,
    input  logic  [FETCH_WIDTH-1:0]   local_correct,
    input  logic  [FETCH_WIDTH-1:0]   gshare_taken,
    input  addr_t [FETCH_WIDTH-1:0]   gshare_pc,
    input  logic  [FETCH_WIDTH-1:0]   gshare_correct,
    output logic  [FETCH_WIDTH-1:0]   predict_taken,
    output addr_t [FETCH_WIDTH-1:0]   predict_pc
);

    logic [1:0] bias;
    logic [1:0] bias_next;

    // nonzero bias trusts local
    assign predict_taken = (bias != 2'd0) ? local_taken : gshare_taken;
    assign predict_pc    = (bias != 2'd0) ? local_pc : gshare_pc;

    // only disagreements move the counter
    always_comb begin
        bias_next = bias;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (upd_valid[i] && local_correct[i] && !gshare_correct[i]) begin
                if (bias_next != 2'd3) begin
                    bias_next = bias_next + 2'd1;
                end
            end else if (upd_valid[i] && gshare_correct[i] && !local_correct[i]) begin
                if (bias_next != 2'd0) begin
                    bias_next = bias_next - 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            bias <= 2'd3;
        end else begin
            bias <= bias_next;
        end
    end

endmodule

/* source/resolve_stage.sv */
`timescale 1ns/1ps

module resolve_stage import bp_pkg::*; #(
    parameter int FETCH_WIDTH = DEFAULT_FETCH_WIDTH
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic  [FETCH_WIDTH-1:0]   resolve_valid,
    input  addr_t [FETCH_WIDTH-1:0]   resolve_pc,
    input  logic  [FETCH_WIDTH-1:0]   resolve_taken,
    input  addr_t [FETCH_WIDTH-1:0]   resolve_target,
    output logic  [FETCH_WIDTH-1:0]   upd_valid,
    output addr_t [FETCH_WIDTH-1:0]   upd_pc,
    output logic  [FETCH_WIDTH-1:0]   upd_taken,
    output addr_t [FETCH_WIDTH-1:0]   upd_target
);

    // slot strobes
    always_ff @(posedge clock) begin
        if (reset) begin
            upd_valid <= '0;
        end else begin
            upd_valid <= resolve_valid;
        end
    end

    // slot payload
    always_ff @(posedge clock) begin
        upd_pc     <= resolve_pc;
        upd_taken  <= resolve_taken;
        upd_target <= resolve_target;
    end

endmodule

/* tb.f */
source/bp_pkg.sv
source/resolve_stage.sv
source/branch_target_buffer.sv
source/local_predictor.sv
source/gshare_predictor.sv
source/predictor_chooser.sv
source/branch_predictor.sv
tests/branch_predictor_chk.sv
tests/branch_predictor_tb.sv

/* tests/branch_predictor_chk.sv */
`timescale 1ns/1ps

module branch_predictor_chk import bp_pkg::*; #(
    parameter int FETCH_WIDTH = DEFAULT_FETCH_WIDTH
) (
    input  logic                      clock,
    input  logic                      reset,
    input  addr_t                     pc_start,
    input  logic  [FETCH_WIDTH-1:0]   predict_taken,
    input  addr_t [FETCH_WIDTH-1:0]   predict_pc
);

    int assert_failures = 0;

    addr_t [FETCH_WIDTH-1:0] slot_addr;

    genvar gi;
    generate
        for (gi = 0; gi < FETCH_WIDTH; gi++) begin : g_slot
            // chained slot address of the selected predictor
            if (gi == 0) begin : g_first
                assign slot_addr[gi] = pc_start;
            end else begin : g_chain
                assign slot_addr[gi] = predict_pc[gi-1];
            end

            a_fall_through: assert property (
                @(posedge clock) disable iff (reset)
                !predict_taken[gi] |-> (predict_pc[gi] == slot_addr[gi] + 32'd4)
            ) else begin
                $error("slot %0d predicted not taken but pc is not slot address plus 4", gi);
                assert_failures++;
            end
        end
    endgenerate

    a_known: assert property (
        @(posedge clock) disable iff (reset)
        !$isunknown({predict_taken, predict_pc})
    ) else begin
        $error("predict_taken or predict_pc is unknown outside reset");
        assert_failures++;
    end

endmodule

bind branch_predictor branch_predictor_chk #(
    .FETCH_WIDTH (FETCH_WIDTH)
) chk_i (
    .clock         (clock),
    .reset         (reset),
    .pc_start      (pc_start),
    .predict_taken (predict_taken),
    .predict_pc    (predict_pc)
);

/* tests/branch_predictor_tb.sv */
`timescale 1ns/1ps

module branch_predictor_tb import bp_pkg::*; ();

    localparam int FETCH_WIDTH  = DEFAULT_FETCH_WIDTH;
    localparam int RESET_CYCLES = 8;
    localparam int SETTLE_LIMIT = 16;
    localparam int MIN_CASES    = 9;
    localparam int RUN_LIMIT_NS = 100000;

    logic                    clock;
    logic                    reset;
    addr_t                   pc_start;
    logic  [FETCH_WIDTH-1:0] resolve_valid;
    addr_t [FETCH_WIDTH-1:0] resolve_pc;
    logic  [FETCH_WIDTH-1:0] resolve_taken;
    addr_t [FETCH_WIDTH-1:0] resolve_target;
    logic  [FETCH_WIDTH-1:0] predict_taken;
    addr_t [FETCH_WIDTH-1:0] predict_pc;

    int   tests_run    = 0;
    int   tests_failed = 0;
    int   mismatches   = 0;
    int   other_errors = 0;
    logic test_ok;

    branch_predictor dut_i (
        .clock          (clock),
        .reset          (reset),
        .pc_start       (pc_start),
        .resolve_valid  (resolve_valid),
        .resolve_pc     (resolve_pc),
        .resolve_taken  (resolve_taken),
        .resolve_target (resolve_target),
        .predict_taken  (predict_taken),
        .predict_pc     (predict_pc)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // watchdog for the whole run
    initial begin
        #(RUN_LIMIT_NS);
        $display("timeout: run did not finish within %0d ns", RUN_LIMIT_NS);
        $display("TB FAILED");
        $finish;
    end

    task automatic wait_cycles(input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clock);
        end
    endtask

    // idle slots carry random payload with the strobes low
    task automatic idle_slots();
        resolve_valid = '0;
        resolve_taken = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            resolve_pc[i]     = $urandom();
            resolve_target[i] = $urandom();
        end
    endtask

    task automatic apply_reset();
        wait_cycles(1);
        #2;
        reset = 1'b1;
        idle_slots();
        wait_cycles(RESET_CYCLES);
        #2;
        reset = 1'b0;
    endtask

    task automatic wait_outputs_known();
        int waited;

        waited = 0;
        #1;
        while ($isunknown({predict_taken, predict_pc}) && waited < SETTLE_LIMIT) begin
            wait_cycles(1);
            #1;
            waited++;
        end
        if ($isunknown({predict_taken, predict_pc})) begin
            $display("timeout: predictions still unknown %0d cycles after reset", SETTLE_LIMIT);
            other_errors++;
        end
    endtask

    task automatic check_taken(
        input string                   name,
        input logic  [FETCH_WIDTH-1:0] expected,
        input logic  [FETCH_WIDTH-1:0] actual
    );
        if (actual !== expected) begin
            $display("FAILED %s expected 0x%h actual 0x%h", name, expected, actual);
            mismatches++;
            test_ok = 1'b0;
        end
    endtask

    task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            $display("FAILED %s expected 0x%h actual 0x%h", name, expected, actual);
            mismatches++;
            test_ok = 1'b0;
        end
    endtask

    // slots present for one cycle, one idle cycle, then sample before the next edge
    task automatic run_case(
        input int                      num,
        input logic                    with_reset,
        input logic  [FETCH_WIDTH-1:0] valid,
        input addr_t [FETCH_WIDTH-1:0] pcs,
        input logic  [FETCH_WIDTH-1:0] taken_bits,
        input addr_t [FETCH_WIDTH-1:0] targets,
        input addr_t                   start,
        input logic  [FETCH_WIDTH-1:0] exp_taken,
        input addr_t [FETCH_WIDTH-1:0] exp_pc
    );
        test_ok = 1'b1;
        if (with_reset) begin
            apply_reset();
            wait_outputs_known();
        end
        wait_cycles(1);
        #2;
        pc_start       = start;
        resolve_valid  = valid;
        resolve_pc     = pcs;
        resolve_taken  = taken_bits;
        resolve_target = targets;
        wait_cycles(1);
        #2;
        idle_slots();
        wait_cycles(1);
        #18;
        check_taken("predict_taken", exp_taken, predict_taken);
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            check_addr($sformatf("predict_pc[%0d]", i), exp_pc[i], predict_pc[i]);
        end
        tests_run++;
        if (test_ok) begin
            $display("test %0d passed", num);
        end else begin
            $display("test %0d failed", num);
            tests_failed++;
        end
    endtask

    initial begin
        int                      fd;
        int                      fields;
        string                   line;
        int                      num;
        logic  [3:0]             rst_flag;
        logic  [FETCH_WIDTH-1:0] valid;
        logic  [FETCH_WIDTH-1:0] taken_bits;
        logic  [FETCH_WIDTH-1:0] exp_taken;
        addr_t                   pc0;
        addr_t                   pc1;
        addr_t                   tgt0;
        addr_t                   tgt1;
        addr_t                   start;
        addr_t                   exp0;
        addr_t                   exp1;
        addr_t [FETCH_WIDTH-1:0] pcs;
        addr_t [FETCH_WIDTH-1:0] targets;
        addr_t [FETCH_WIDTH-1:0] exp_pc;

        void'($urandom(11));
        reset          = 1'b1;
        pc_start       = '0;
        resolve_valid  = '0;
        resolve_pc     = '0;
        resolve_taken  = '0;
        resolve_target = '0;

        apply_reset();
        wait_outputs_known();

        fd = $fopen("tests/predictor_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the case file tests/predictor_cases.txt");
            other_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                fields = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h",
                                 num, rst_flag, valid, pc0, pc1, taken_bits,
                                 tgt0, tgt1, start, exp_taken, exp0, exp1);
                if (fields != 12) begin
                    $display("case line has %0d fields instead of 12: %s", fields, line);
                    other_errors++;
                end else begin
                    pcs[0]     = pc0;
                    pcs[1]     = pc1;
                    targets[0] = tgt0;
                    targets[1] = tgt1;
                    exp_pc[0]  = exp0;
                    exp_pc[1]  = exp1;
                    run_case(num, rst_flag != 0, valid, pcs, taken_bits, targets,
                             start, exp_taken, exp_pc);
                end
            end
            $fclose(fd);
            if (tests_run < MIN_CASES) begin
                $display("case file is short, %0d tests read where at least %0d are expected",
                         tests_run, MIN_CASES);
                other_errors++;
            end
        end

        if (dut_i.chk_i.assert_failures != 0) begin
            $display("bound checker saw %0d assertion failures", dut_i.chk_i.assert_failures);
            other_errors++;
        end

        $display("%0d tests run, %0d passed, %0d failed, %0d mismatches, %0d other errors",
                 tests_run, tests_run - tests_failed, tests_failed, mismatches, other_errors);
        if (tests_failed == 0 && mismatches == 0 && other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* tests/predictor_cases.txt */
# test reset valid pc0 pc1 taken target0 target1 pc_start exp_taken exp_pc0 exp_pc1
# valid, taken and exp_taken are slot masks with slot 0 in bit 0, all fields but test in hex
1 0 0 00000000 00000000 0 00000000 00000000 00001000 0 00001004 00001008
2 0 1 00001000 00000000 1 00003000 00000000 00001000 1 00003000 00003004
3 0 1 00001104 00000000 0 00005000 00000000 00002000 0 00002004 00002008
4 0 1 00001000 00000000 0 00000000 00000000 00001000 0 00001004 00001008
5 0 3 00001008 0000100c 3 00004000 00004100 00001008 0 0000100c 00001010
6 0 3 00001004 00001020 0 00000000 00000000 00001000 0 00001004 00001008
7 0 1 00001038 00000000 1 00008000 00000000 00001038 1 00008000 00008004
8 1 0 00000000 00000000 0 00000000 00000000 00001038 0 0000103c 00001040
9 0 0 00000000 00000000 0 00000000 00000000 0000fffc 0 00010000 00010004
